//--- hdl/csr_pkg.sv
package csr_pkg;

    // ==============================
    // widths and types
    // ==============================

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [2*XLEN-1:0] dword_t;
    typedef logic [11:0]       csr_addr_t;
    typedef logic [31:0]       inst_t;

    // ==============================
    // csr addresses
    // ==============================

    localparam csr_addr_t CSR_ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_ADDR_MISA     = 12'h301;
    localparam csr_addr_t CSR_ADDR_MIE      = 12'h304;
    localparam csr_addr_t CSR_ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_ADDR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_ADDR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_ADDR_MIP      = 12'h344;
    localparam csr_addr_t CSR_ADDR_MCYCLE   = 12'hB00;
    localparam csr_addr_t CSR_ADDR_MCYCLEH  = 12'hB80;
    localparam csr_addr_t CSR_ADDR_CYCLE    = 12'hC00;
    localparam csr_addr_t CSR_ADDR_CYCLEH   = 12'hC80;
    // non-standard, custom machine read-write space
    localparam csr_addr_t CSR_ADDR_MTIMECMP  = 12'h7C0;
    localparam csr_addr_t CSR_ADDR_MTIMECMPH = 12'h7C1;

    // ==============================
    // instruction codes
    // ==============================

    localparam logic [2:0] F3_PRIV   = 3'b000;
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET   = 12'h302;

    // trap causes
    localparam xlen_t MCAUSE_ECALL_M = 32'd11;
    localparam xlen_t MCAUSE_BREAK   = 32'd3;

    // mxl = 1, extension I only
    localparam xlen_t MISA_RV32I = 32'h4000_0100;

    // field positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSIE_BIT         = 3;
    localparam int MTIE_BIT         = 7;
    localparam int MEIE_BIT         = 11;

endpackage

//--- hdl/csr_decode.sv
`timescale 1ns/100ps

module csr_decode (
    input  logic               instruction_vld,
    input  csr_pkg::inst_t     instruction_pld,
    input  csr_pkg::xlen_t     rs1_val,
    input  logic               rd_en,
    input  csr_pkg::xlen_t     csr_rdata,
    output csr_pkg::csr_addr_t csr_addr,
    output logic               csr_wren,
    output csr_pkg::xlen_t     csr_wdata,
    output logic               trap_en,
    output logic               mret_en,
    output csr_pkg::xlen_t     trap_cause
);
    import csr_pkg::*;

    logic [2:0]  funct3;
    logic [11:0] funct12;
    xlen_t       imm_ext;
    logic        is_csr_op;
    logic        is_priv;

    assign funct3   = instruction_pld[14:12];
    assign funct12  = instruction_pld[31:20];
    assign csr_addr = instruction_pld[31:20];
    // zimm sits in the rs1 field
    assign imm_ext  = {{(XLEN-5){1'b0}}, instruction_pld[19:15]};

    // write value from the old csr value
    always_comb begin
        is_csr_op = 1'b1;
        case (funct3)
            F3_CSRRW  : csr_wdata = rs1_val;
            F3_CSRRS  : csr_wdata = csr_rdata | rs1_val;
            F3_CSRRC  : csr_wdata = csr_rdata & ~rs1_val;
            F3_CSRRWI : csr_wdata = imm_ext;
            F3_CSRRSI : csr_wdata = csr_rdata | imm_ext;
            F3_CSRRCI : csr_wdata = csr_rdata & ~imm_ext;
            default   : begin
                csr_wdata = '0;
                is_csr_op = 1'b0;
            end
        endcase
    end

    assign csr_wren = instruction_vld & rd_en & is_csr_op;

    assign is_priv    = instruction_vld & (funct3 == F3_PRIV);
    assign trap_en    = is_priv & ((funct12 == F12_ECALL) | (funct12 == F12_EBREAK));
    assign mret_en    = is_priv & (funct12 == F12_MRET);
    assign trap_cause = (funct12 == F12_EBREAK) ? MCAUSE_BREAK : MCAUSE_ECALL_M;

endmodule

//--- hdl/csr_read_mux.sv
`timescale 1ns/100ps

module csr_read_mux (
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::xlen_t     mstatus,
    input  csr_pkg::xlen_t     mie,
    input  csr_pkg::xlen_t     mtvec,
    input  csr_pkg::xlen_t     mepc,
    input  csr_pkg::xlen_t     mcause,
    input  csr_pkg::xlen_t     mtval,
    input  csr_pkg::xlen_t     mscratch,
    input  csr_pkg::dword_t    cycle,
    input  csr_pkg::dword_t    mtimecmp,
    input  logic               mtip,
    input  logic               intr_meip,
    input  logic               intr_msip,
    output csr_pkg::xlen_t     csr_rdata
);
    import csr_pkg::*;

    xlen_t mip;

    // pending bits share positions with mie
    always_comb begin
        mip           = '0;
        mip[MSIE_BIT] = intr_msip;
        mip[MTIE_BIT] = mtip;
        mip[MEIE_BIT] = intr_meip;
    end

    always_comb begin
        case (csr_addr)
            CSR_ADDR_MSTATUS   : csr_rdata = mstatus;
            CSR_ADDR_MISA      : csr_rdata = MISA_RV32I;
            CSR_ADDR_MIE       : csr_rdata = mie;
            CSR_ADDR_MTVEC     : csr_rdata = mtvec;
            CSR_ADDR_MSCRATCH  : csr_rdata = mscratch;
            CSR_ADDR_MEPC      : csr_rdata = mepc;
            CSR_ADDR_MCAUSE    : csr_rdata = mcause;
            CSR_ADDR_MTVAL     : csr_rdata = mtval;
            CSR_ADDR_MIP       : csr_rdata = mip;
            // user counters alias the machine ones
            CSR_ADDR_MCYCLE,
            CSR_ADDR_CYCLE     : csr_rdata = cycle[XLEN-1:0];
            CSR_ADDR_MCYCLEH,
            CSR_ADDR_CYCLEH    : csr_rdata = cycle[2*XLEN-1:XLEN];
            CSR_ADDR_MTIMECMP  : csr_rdata = mtimecmp[XLEN-1:0];
            CSR_ADDR_MTIMECMPH : csr_rdata = mtimecmp[2*XLEN-1:XLEN];
            default            : csr_rdata = '0;
        endcase
    end

endmodule

//--- hdl/csr_trap_regs.sv
`timescale 1ns/100ps

module csr_trap_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_addr_t csr_addr,
    input  logic               csr_wren,
    input  csr_pkg::xlen_t     csr_wdata,
    input  logic               trap_en,
    input  logic               mret_en,
    input  csr_pkg::xlen_t     trap_cause,
    input  csr_pkg::inst_t     instruction_pld,
    input  csr_pkg::xlen_t     pc,
    output csr_pkg::xlen_t     mstatus,
    output csr_pkg::xlen_t     mie,
    output csr_pkg::xlen_t     mtvec,
    output csr_pkg::xlen_t     mepc,
    output csr_pkg::xlen_t     mcause,
    output csr_pkg::xlen_t     mtval,
    output csr_pkg::xlen_t     mscratch
);
    import csr_pkg::*;

    // ==============================
    // mstatus, only mie and mpie
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus <= '0;
        end else if (trap_en) begin
            mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
            mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
        end else if (mret_en) begin
            mstatus[MSTATUS_MIE_BIT]  <= mstatus[MSTATUS_MPIE_BIT];
            mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
        end else if (csr_wren && csr_addr == CSR_ADDR_MSTATUS) begin
            mstatus[MSTATUS_MIE_BIT]  <= csr_wdata[MSTATUS_MIE_BIT];
            mstatus[MSTATUS_MPIE_BIT] <= csr_wdata[MSTATUS_MPIE_BIT];
        end
    end

    // ==============================
    // trap setup
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie   <= '0;
            mtvec <= '0;
        end else if (csr_wren) begin
            if (csr_addr == CSR_ADDR_MIE) begin
                mie[MSIE_BIT] <= csr_wdata[MSIE_BIT];
                mie[MTIE_BIT] <= csr_wdata[MTIE_BIT];
                mie[MEIE_BIT] <= csr_wdata[MEIE_BIT];
            end
            if (csr_addr == CSR_ADDR_MTVEC) begin
                mtvec[XLEN-1:2] <= csr_wdata[XLEN-1:2];
                // mode 2 and 3 reserved, old mode kept
                if (!csr_wdata[1]) begin
                    mtvec[1:0] <= csr_wdata[1:0];
                end
            end
        end
    end

    // ==============================
    // trap handling
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mscratch <= '0;
        end else if (trap_en) begin
            mepc   <= pc;
            mcause <= trap_cause;
            // faulting instruction word
            mtval  <= instruction_pld;
        end else if (csr_wren) begin
            case (csr_addr)
                CSR_ADDR_MEPC     : mepc     <= csr_wdata;
                CSR_ADDR_MCAUSE   : mcause   <= csr_wdata;
                CSR_ADDR_MTVAL    : mtval    <= csr_wdata;
                CSR_ADDR_MSCRATCH : mscratch <= csr_wdata;
                default           : ;
            endcase
        end
    end

endmodule

//--- hdl/csr_timer.sv
`timescale 1ns/100ps

module csr_timer (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_addr_t csr_addr,
    input  logic               csr_wren,
    input  csr_pkg::xlen_t     csr_wdata,
    output csr_pkg::dword_t    cycle,
    output csr_pkg::dword_t    mtimecmp,
    output logic               mtip
);
    import csr_pkg::*;

    // free-running, no write path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + dword_t'(1);
        end
    end

    // compare value, written one half at a time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= '0;
        end else if (csr_wren) begin
            if (csr_addr == CSR_ADDR_MTIMECMP) begin
                mtimecmp[XLEN-1:0] <= csr_wdata;
            end
            if (csr_addr == CSR_ADDR_MTIMECMPH) begin
                mtimecmp[2*XLEN-1:XLEN] <= csr_wdata;
            end
        end
    end

    assign mtip = (cycle > mtimecmp);

endmodule

//--- hdl/csr_irq_ctrl.sv
`timescale 1ns/100ps

module csr_irq_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  csr_pkg::xlen_t mstatus,
    input  csr_pkg::xlen_t mie,
    input  logic           mtip,
    input  logic           intr_meip,
    input  logic           intr_msip,
    input  logic           instruction_vld,
    input  logic           instruction_is_intr,
    input  logic           intr_req_rdy,
    output logic           intr_req_vld
);
    import csr_pkg::*;

    logic sent;
    logic pending;

    assign pending = (mie[MEIE_BIT] & intr_meip)
                   | (mie[MTIE_BIT] & mtip)
                   | (mie[MSIE_BIT] & intr_msip);

    // request handed over, wait for the pseudo-instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sent <= 1'b0;
        end else if (intr_req_vld && intr_req_rdy) begin
            sent <= 1'b1;
        end else if (instruction_vld && instruction_is_intr) begin
            sent <= 1'b0;
        end
    end

    assign intr_req_vld = ~sent & mstatus[MSTATUS_MIE_BIT] & pending;

endmodule

//--- hdl/csr_unit.sv
`timescale 1ns/100ps

module csr_unit (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           instruction_vld,
    output logic           instruction_rdy,
    input  csr_pkg::inst_t instruction_pld,
    input  csr_pkg::xlen_t rs1_val,
    input  csr_pkg::xlen_t pc,
    input  logic           rd_en,
    input  logic           instruction_is_intr,
    output logic           reg_wr_en,
    output csr_pkg::xlen_t reg_val,
    output logic           pc_update_en,
    output csr_pkg::xlen_t pc_val,
    output logic           intr_req_vld,
    input  logic           intr_req_rdy,
    input  logic           intr_meip,
    input  logic           intr_msip
);
    import csr_pkg::*;

    csr_addr_t csr_addr;
    logic      csr_wren;
    xlen_t     csr_wdata;
    xlen_t     csr_rdata;
    logic      trap_en;
    logic      mret_en;
    xlen_t     trap_cause;
    xlen_t     mstatus;
    xlen_t     mie;
    xlen_t     mtvec;
    xlen_t     mepc;
    xlen_t     mcause;
    xlen_t     mtval;
    xlen_t     mscratch;
    dword_t    cycle;
    dword_t    mtimecmp;
    logic      mtip;

    // single-cycle unit, never stalls
    assign instruction_rdy = 1'b1;

    assign reg_wr_en    = instruction_vld & rd_en;
    assign reg_val      = csr_rdata;
    assign pc_update_en = trap_en | mret_en;

    // redirect target
    always_comb begin
        if (trap_en) begin
            pc_val = mtvec;
        end else if (mret_en) begin
            pc_val = mepc;
        end else begin
            pc_val = '0;
        end
    end

    csr_decode u_decode (
        .instruction_vld (instruction_vld),
        .instruction_pld (instruction_pld),
        .rs1_val         (rs1_val),
        .rd_en           (rd_en),
        .csr_rdata       (csr_rdata),
        .csr_addr        (csr_addr),
        .csr_wren        (csr_wren),
        .csr_wdata       (csr_wdata),
        .trap_en         (trap_en),
        .mret_en         (mret_en),
        .trap_cause      (trap_cause)
    );

    csr_read_mux u_read_mux (
        .csr_addr  (csr_addr),
        .mstatus   (mstatus),
        .mie       (mie),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .mcause    (mcause),
        .mtval     (mtval),
        .mscratch  (mscratch),
        .cycle     (cycle),
        .mtimecmp  (mtimecmp),
        .mtip      (mtip),
        .intr_meip (intr_meip),
        .intr_msip (intr_msip),
        .csr_rdata (csr_rdata)
    );

    csr_trap_regs u_trap_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .csr_addr        (csr_addr),
        .csr_wren        (csr_wren),
        .csr_wdata       (csr_wdata),
        .trap_en         (trap_en),
        .mret_en         (mret_en),
        .trap_cause      (trap_cause),
        .instruction_pld (instruction_pld),
        .pc              (pc),
        .mstatus         (mstatus),
        .mie             (mie),
        .mtvec           (mtvec),
        .mepc            (mepc),
        .mcause          (mcause),
        .mtval           (mtval),
        .mscratch        (mscratch)
    );

    csr_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_addr  (csr_addr),
        .csr_wren  (csr_wren),
        .csr_wdata (csr_wdata),
        .cycle     (cycle),
        .mtimecmp  (mtimecmp),
        .mtip      (mtip)
    );

    csr_irq_ctrl u_irq_ctrl (
        .clk                 (clk),
        .rst_n               (rst_n),
        .mstatus             (mstatus),
        .mie                 (mie),
        .mtip                (mtip),
        .intr_meip           (intr_meip),
        .intr_msip           (intr_msip),
        .instruction_vld     (instruction_vld),
        .instruction_is_intr (instruction_is_intr),
        .intr_req_rdy        (intr_req_rdy),
        .intr_req_vld        (intr_req_vld)
    );

endmodule

//--- bench/csr_checker.sv
`timescale 1ns/100ps

module csr_checker (
    input logic clk,
    input logic rst_n,
    input logic instruction_vld,
    input logic instruction_is_intr,
    input logic reg_wr_en,
    input logic pc_update_en,
    input logic intr_req_vld,
    input logic intr_req_rdy
);

    int fail_count = 0;

    // redirect only comes with an accepted instruction
    assert property (@(posedge clk) disable iff (!rst_n)
        pc_update_en |-> instruction_vld)
        else begin
            $error("pc_update_en high without instruction_vld");
            fail_count++;
        end

    // request held under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        intr_req_vld && !intr_req_rdy && !(instruction_vld && instruction_is_intr)
        |=> intr_req_vld)
        else begin
            $error("intr_req_vld dropped before rdy or intr instruction");
            fail_count++;
        end

    assert property (@(posedge clk) !rst_n |-> !reg_wr_en)
        else begin
            $error("reg_wr_en high during reset");
            fail_count++;
        end

endmodule

//--- bench/tb_csr_unit.sv
`timescale 1ns/100ps

module tb_csr_unit;
    import csr_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int FIELDS     = 9;
    localparam int MAX_LINES  = 64;

    logic  clk;
    logic  rst_n;
    logic  instruction_vld;
    logic  instruction_rdy;
    inst_t instruction_pld;
    xlen_t rs1_val;
    xlen_t pc;
    logic  rd_en;
    logic  instruction_is_intr;
    logic  reg_wr_en;
    xlen_t reg_val;
    logic  pc_update_en;
    xlen_t pc_val;
    logic  intr_req_vld;
    logic  intr_req_rdy;
    logic  intr_meip;
    logic  intr_msip;

    // FIELDS words for each instruction line
    logic [31:0] tdata [0:FIELDS*MAX_LINES-1];
    int          n_lines;
    int          cycles;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    logic        loaded;
    logic [31:0] lcg_state;
    xlen_t       scratch_model;
    xlen_t       last_cycle;
    logic        last_was_cycle;

    csr_unit u_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .instruction_vld     (instruction_vld),
        .instruction_rdy     (instruction_rdy),
        .instruction_pld     (instruction_pld),
        .rs1_val             (rs1_val),
        .pc                  (pc),
        .rd_en               (rd_en),
        .instruction_is_intr (instruction_is_intr),
        .reg_wr_en           (reg_wr_en),
        .reg_val             (reg_val),
        .pc_update_en        (pc_update_en),
        .pc_val              (pc_val),
        .intr_req_vld        (intr_req_vld),
        .intr_req_rdy        (intr_req_rdy),
        .intr_meip           (intr_meip),
        .intr_msip           (intr_msip)
    );

    bind csr_unit csr_checker u_checker (
        .clk                 (clk),
        .rst_n               (rst_n),
        .instruction_vld     (instruction_vld),
        .instruction_is_intr (instruction_is_intr),
        .reg_wr_en           (reg_wr_en),
        .pc_update_en        (pc_update_en),
        .intr_req_vld        (intr_req_vld),
        .intr_req_rdy        (intr_req_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // run limit scales with the data file
    initial begin
        cycles = 0;
        wait (loaded);
        while (cycles <= n_lines * 4 + 50) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run stopped after %0d cycles", cycles);
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            test_errors++;
        end
    endtask

    task automatic close_test(input logic [31:0] num);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d: ok", num);
        end else begin
            $display("test %0d: %0d mismatches", num, test_errors);
            tests_failed++;
            errors += test_errors;
        end
        test_errors = 0;
    endtask

    task automatic apply_line(input int idx);
        int         base;
        inst_t      inst;
        xlen_t      rs1;
        xlen_t      exp_val;
        xlen_t      operand;
        logic [2:0] f3;
        csr_addr_t  addr;
        logic       is_cycle;

        base     = idx * FIELDS;
        inst     = tdata[base+1];
        rs1      = tdata[base+2];
        exp_val  = tdata[base+6];
        f3       = inst[14:12];
        addr     = inst[31:20];
        is_cycle = (f3 != F3_PRIV) && (addr == CSR_ADDR_MCYCLE || addr == CSR_ADDR_CYCLE);

        // mscratch lines follow the testbench model
        if (f3 != F3_PRIV && addr == CSR_ADDR_MSCRATCH) begin
            // register forms take random operands
            if (!f3[2]) begin
                lcg_state = lcg_next(lcg_state);
                rs1       = lcg_state;
                operand   = rs1;
            end else begin
                operand = {27'd0, inst[19:15]};
            end
            exp_val = scratch_model;
            case (f3[1:0])
                2'b01   : scratch_model = operand;
                2'b10   : scratch_model = scratch_model | operand;
                2'b11   : scratch_model = scratch_model & ~operand;
                default : ;
            endcase
        end

        @(negedge clk);
        instruction_vld     = 1'b1;
        instruction_pld     = inst;
        rs1_val             = rs1;
        pc                  = tdata[base+3];
        rd_en               = tdata[base+4][0];
        instruction_is_intr = tdata[base+5][0];
        #1;
        check_value("instruction_rdy", 32'(instruction_rdy), 32'd1);
        check_value("reg_wr_en", 32'(reg_wr_en), tdata[base+4]);
        check_value("pc_update_en", 32'(pc_update_en), tdata[base+7]);
        check_value("pc_val", pc_val, tdata[base+8]);
        if (is_cycle) begin
            if (last_was_cycle && !(reg_val > last_cycle)) begin
                $display("mcycle did not advance between two back-to-back reads");
                test_errors++;
            end
            last_cycle = reg_val;
        end else begin
            check_value("reg_val", reg_val, exp_val);
        end
        last_was_cycle = is_cycle;
    endtask

    // request must hold under back-pressure and drop once taken
    task automatic intr_handshake();
        @(negedge clk);
        instruction_vld = 1'b0;
        #1;
        check_value("intr_req_vld", 32'(intr_req_vld), 32'd1);
        repeat (3) begin
            @(negedge clk);
            #1;
            check_value("intr_req_vld", 32'(intr_req_vld), 32'd1);
        end
        @(negedge clk);
        intr_req_rdy = 1'b1;
        @(negedge clk);
        intr_req_rdy = 1'b0;
        #1;
        check_value("intr_req_vld", 32'(intr_req_vld), 32'd0);
    endtask

    initial begin
        loaded              = 1'b0;
        rst_n               = 1'b0;
        instruction_vld     = 1'b0;
        instruction_pld     = '0;
        rs1_val             = '0;
        pc                  = '0;
        rd_en               = 1'b0;
        instruction_is_intr = 1'b0;
        intr_req_rdy        = 1'b0;
        intr_meip           = 1'b0;
        intr_msip           = 1'b0;
        errors              = 0;
        test_errors         = 0;
        tests_run           = 0;
        tests_failed        = 0;
        lcg_state           = 32'h4472f2cb;
        scratch_model       = '0;
        last_cycle          = '0;
        last_was_cycle      = 1'b0;

        $readmemh("bench/csr_testdata.hex", tdata);
        n_lines = 0;
        while (n_lines < MAX_LINES && !$isunknown(tdata[n_lines*FIELDS])
               && tdata[n_lines*FIELDS] != 0) begin
            n_lines++;
        end
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < n_lines; i++) begin
            if (i > 0 && tdata[i*FIELDS] != tdata[(i-1)*FIELDS]) begin
                close_test(tdata[(i-1)*FIELDS]);
            end
            if (tdata[i*FIELDS+5][0]) begin
                intr_handshake();
            end
            apply_line(i);
            if (tdata[i*FIELDS+5][0]) begin
                @(negedge clk);
                instruction_vld = 1'b0;
                #1;
                // sent flag cleared while the timer is still pending
                check_value("intr_req_vld", 32'(intr_req_vld), 32'd1);
            end
        end
        if (n_lines > 0) begin
            close_test(tdata[(n_lines-1)*FIELDS]);
        end else begin
            $display("no instruction lines could be read from the data file");
            errors++;
        end
        @(negedge clk);
        instruction_vld = 1'b0;

        if (u_dut.u_checker.fail_count != 0) begin
            $display("%0d assertion failures in the checker", u_dut.u_checker.fail_count);
            errors += u_dut.u_checker.fail_count;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- bench/csr_testdata.hex
// test inst rs1 pc rd_en is_intr exp_reg_val exp_pc_update_en exp_pc_val
// mscratch lines take rs1 and reg_val from the testbench model, zeros here
1 340110F3 0 0 1 0 0 0 0
1 340120F3 0 0 1 0 0 0 0
1 340130F3 0 0 1 0 0 0 0
// immediate forms, mie mask, mtvec reserved mode
2 340AD0F3 0 0 1 0 0 0 0
2 340560F3 0 0 1 0 0 0 0
2 3401F0F3 0 0 1 0 0 0 0
2 340020F3 0 0 1 0 0 0 0
2 304110F3 FFFFFFFF 0 1 0 0 0 0
2 304020F3 0 0 1 0 888 0 0
2 304110F3 0 0 1 0 888 0 0
2 305110F3 101 0 1 0 0 0 0
2 305110F3 202 0 1 0 101 0 0
// ecall and ebreak
3 305110F3 800 0 1 0 201 0 0
3 300460F3 0 0 1 0 0 0 0
3 00000073 0 100 0 0 0 1 800
3 341020F3 0 0 1 0 100 0 0
3 342020F3 0 0 1 0 B 0 0
3 343020F3 0 0 1 0 73 0 0
3 300460F3 0 0 1 0 80 0 0
3 00100073 0 204 0 0 0 1 800
3 341020F3 0 0 1 0 204 0 0
3 342020F3 0 0 1 0 3 0 0
3 343020F3 0 0 1 0 100073 0 0
// mret
4 30200073 0 300 0 0 0 1 204
4 300020F3 0 0 1 0 88 0 0
// misa, unknown address, mcycle twice
5 301020F3 0 0 1 0 40000100 0 0
5 3A0020F3 0 0 1 0 0 0 0
5 B00020F3 0 0 1 0 0 0 0
5 B00020F3 0 0 1 0 0 0 0
// timer interrupt, last line is the intr pseudo-instruction
6 7C0110F3 0 0 1 0 0 0 0
6 304120F3 80 0 1 0 0 0 0
6 344020F3 0 0 1 1 80 0 0

//--- flist.f
hdl/csr_pkg.sv
hdl/csr_decode.sv
hdl/csr_read_mux.sv
hdl/csr_trap_regs.sv
hdl/csr_timer.sv
hdl/csr_irq_ctrl.sv
hdl/csr_unit.sv
bench/csr_checker.sv
bench/tb_csr_unit.sv

//--- Makefile
SIM   := verilator
FLAGS := --binary --timing --assert
TOP   := tb_csr_unit
FLIST := flist.f

OBJ   := obj_dir
BIN   := $(OBJ)/V$(TOP)
LOG   := sim.log
SRCS  := $(shell cat $(FLIST))
DATA  := bench/csr_testdata.hex

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)

run: $(BIN) $(DATA)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "Some tests failed" $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
